//--- hdl/deser_macros.svh
// Build-time configuration of the 8-to-32 bit flit deserializer
`ifndef DESER_MACROS_SVH
`define DESER_MACROS_SVH

// ---------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------

// Width of one flit on the narrow push side
`define DESER_PUSH_W 8
// Width of one flit on the wide pop side
`define DESER_POP_W 32
// Number of push flits that fill one pop flit
`define DESER_RATIO 4
// Enough bits to count positions 0 to ratio minus 1
`define DESER_ID_W 2
// Sideband metadata carried alongside each flit
`define DESER_META_W 3

// ---------------------------------------------------------------------
// Byte order
// ---------------------------------------------------------------------

// Set to 1 so the first push flit lands in the most-significant slot
`define DESER_MSB_FIRST 1

`endif

//--- hdl/deser_pkg.sv
// Shared vector types and flit structs for the flit deserializer
`include "deser_macros.svh"

package deser_pkg;

  // ---------------------------------------------------------------------
  // Plain vectors
  // ---------------------------------------------------------------------

  // One narrow slice as it arrives on the push side
  typedef logic [`DESER_PUSH_W-1:0] push_data_t;

  // The full data word of one pop flit
  typedef logic [`DESER_POP_W-1:0] pop_data_t;

  // Position of a push flit inside the pop flit under construction
  // Also reused for the count of unfilled trailing slots
  typedef logic [`DESER_ID_W-1:0] flit_id_t;

  // Sideband metadata that is not serialized
  typedef logic [`DESER_META_W-1:0] meta_t;

  // ---------------------------------------------------------------------
  // Structs
  // ---------------------------------------------------------------------

  // Everything the push source presents with one push flit
  typedef struct packed {
    push_data_t data;
    logic       last;
    meta_t      meta;
  } push_flit_t;

  // The slices held in registers while a pop flit builds up
  // Slot 0 is the lowest element and the final slot is never stored
  typedef push_data_t [`DESER_RATIO-2:0] staged_slices_t;

  // Everything the pop side sees with one pop flit
  // The don't-care count is only meaningful when last is set
  typedef struct packed {
    pop_data_t data;
    logic      last;
    flit_id_t  dont_care_count;
    meta_t     meta;
  } pop_flit_t;

endpackage

//--- hdl/slot_tracker.sv
// Push flit position counter and push-side handshake of the deserializer
`include "deser_macros.svh"

module slot_tracker (
  // Rising-edge clock
  input  logic                clk,
  // Asynchronous active-low reset
  input  logic                arst_n,

  // Push-side handshake and the last marker of the presented flit
  input  logic                push_valid,
  input  logic                push_last,
  output logic                push_ready,

  // Pop-side ready, needed to let a completing push through
  input  logic                pop_ready,

  // Position of the presented push flit within the pop flit
  output deser_pkg::flit_id_t flit_id,
  // Accepted push that does not complete the pop flit
  output logic                slot_load,
  // The presented push flit completes the pop flit
  output logic                flit_complete
);

  import deser_pkg::*;

  // Position of the last slot in a pop flit
  localparam flit_id_t FINAL_ID = flit_id_t'(`DESER_RATIO - 1);

  logic at_final;
  logic push_fire;
  logic pop_fire;

  // ---------------------------------------------------------------------
  // Completion decode
  // ---------------------------------------------------------------------

  // The counter sits on the final slot so this push fills the pop flit
  assign at_final = (flit_id == FINAL_ID);

  // A valid push completes the pop flit when it is marked last
  // or when it lands in the final slot
  assign flit_complete = push_valid && (push_last || at_final);

  // ---------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------

  // A non-completing push only needs a free staging register
  // and there always is one below the final slot
  // A completing push has to leave together with the pop flit
  // so it waits for the pop side
  assign push_ready = !flit_complete || pop_ready;

  assign push_fire = push_valid && push_ready;

  // The pop flit transfers on the same edge as its completing push
  assign pop_fire = flit_complete && pop_ready;

  // Only a push that stays in the staging registers is a load
  assign slot_load = push_fire && !flit_complete;

  // ---------------------------------------------------------------------
  // Position counter
  // ---------------------------------------------------------------------

  // Counts accepted pushes inside the current pop flit
  // Returns to 0 when the pop flit leaves so the next one starts at slot 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_id <= '0;
    end else if (pop_fire) begin
      flit_id <= '0;
    end else if (slot_load) begin
      flit_id <= flit_id + flit_id_t'(1);
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // A load moves the counter forward and never past the final slot
  // Stepping past the final slot would wrap the counter back to 0 without a pop
  counter_in_range_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    slot_load |=> (flit_id != '0)
  ) else $error("slot_tracker: flit position left its range after a load");

endmodule

//--- hdl/slice_stager.sv
// Staging registers that hold every push slice except the final one
`include "deser_macros.svh"

module slice_stager (
  // Rising-edge clock
  input  logic                      clk,
  // Asynchronous active-low reset
  input  logic                      arst_n,

  // Data of the presented push flit
  input  deser_pkg::push_data_t     push_data,
  // Slot that the presented push flit belongs to
  input  deser_pkg::flit_id_t       flit_id,
  // Accepted push that does not complete the pop flit
  input  logic                      slot_load,

  // Registered slices, slot 0 lowest
  output deser_pkg::staged_slices_t staged
);

  import deser_pkg::*;

  // Position of the last slot in a pop flit
  localparam flit_id_t FINAL_ID = flit_id_t'(`DESER_RATIO - 1);

  // One load enable per staging register
  logic [`DESER_RATIO-2:0] load_en;

  // ---------------------------------------------------------------------
  // Demux
  // ---------------------------------------------------------------------

  // Only the register named by the current position is enabled
  // The other registers keep their value and do not toggle
  always_comb begin
    for (int i = 0; i < `DESER_RATIO - 1; i++) begin
      load_en[i] = slot_load && (flit_id == flit_id_t'(i));
    end
  end

  // ---------------------------------------------------------------------
  // Registers
  // ---------------------------------------------------------------------

  // Slices stay in place until the same slot is loaded again
  // Stale slices from a shorter packet are masked off in the pop stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      staged <= '0;
    end else begin
      for (int i = 0; i < `DESER_RATIO - 1; i++) begin
        if (load_en[i]) begin
          staged[i] <= push_data;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // The final slice always passes straight through to the pop side
  // so the tracker must never ask for it to be stored
  no_final_load_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    slot_load |-> (flit_id < FINAL_ID)
  ) else $error("slice_stager: load aimed at the final slot");

endmodule

//--- hdl/pop_assembler.sv
// Output stage that merges staged and live slices into the pop flit
`include "deser_macros.svh"

module pop_assembler (
  // The presented push flit, including last and metadata
  input  deser_pkg::push_flit_t     push_flit,
  // Slot that the presented push flit belongs to
  input  deser_pkg::flit_id_t       flit_id,
  // Slices already captured for this pop flit
  input  deser_pkg::staged_slices_t staged,

  // Assembled pop flit, valid whenever the tracker completes it
  output deser_pkg::pop_flit_t      pop_flit
);

  import deser_pkg::*;

  // Position of the last slot in a pop flit
  localparam flit_id_t FINAL_ID = flit_id_t'(`DESER_RATIO - 1);

  // Staged slices padded to a full set of slots
  push_data_t [`DESER_RATIO-1:0] held;
  // Slot contents in arrival order, slot 0 first
  push_data_t [`DESER_RATIO-1:0] slot_data;
  // Slot contents in their final byte positions, element 0 lowest
  push_data_t [`DESER_RATIO-1:0] ordered;

  flit_id_t dont_care_count;

  // ---------------------------------------------------------------------
  // Slot selection
  // ---------------------------------------------------------------------

  // The final slot has no register, so its padded entry is zero
  // It is never selected from here anyway because no slot lies above it
  assign held = {push_data_t'(0), staged};

  // The slot at the current position takes the live push data
  // Slots below it were filled by earlier pushes of this pop flit
  // Slots above it are unfilled in a partial flit and read as zero
  always_comb begin
    for (int i = 0; i < `DESER_RATIO; i++) begin
      if (flit_id == flit_id_t'(i)) begin
        slot_data[i] = push_flit.data;
      end else if (flit_id > flit_id_t'(i)) begin
        slot_data[i] = held[i];
      end else begin
        slot_data[i] = '0;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Byte order
  // ---------------------------------------------------------------------

  if (`DESER_MSB_FIRST != 0) begin : gen_msb_first
    // Slot 0 goes to the top byte and the zero fill ends up at the bottom
    always_comb begin
      for (int i = 0; i < `DESER_RATIO; i++) begin
        ordered[`DESER_RATIO-1-i] = slot_data[i];
      end
    end
  end else begin : gen_lsb_first
    // Slot 0 goes to the bottom byte and the zero fill ends up at the top
    assign ordered = slot_data;
  end

  // ---------------------------------------------------------------------
  // Sideband fields
  // ---------------------------------------------------------------------

  // Number of trailing slots left unfilled by an early last
  // A pop flit without last is always full
  assign dont_care_count = push_flit.last ? (FINAL_ID - flit_id) : '0;

  // Metadata is constant across the pop flit, so the live copy is used
  always_comb begin
    pop_flit.data            = ordered;
    pop_flit.last            = push_flit.last;
    pop_flit.dont_care_count = dont_care_count;
    pop_flit.meta            = push_flit.meta;
  end

endmodule

//--- hdl/deser_top.sv
// Top level of the flit deserializer that wires its three stages together
module deser_top (
  // Rising-edge clock
  input  logic                  clk,
  // Asynchronous active-low reset
  input  logic                  arst_n,

  // Push side, one narrow flit per transfer
  input  logic                  push_valid,
  input  deser_pkg::push_flit_t push_flit,
  output logic                  push_ready,

  // Pop side, one wide flit per transfer
  output logic                  pop_valid,
  output deser_pkg::pop_flit_t  pop_flit,
  input  logic                  pop_ready
);

  import deser_pkg::*;

  // Position of the presented push flit
  flit_id_t       flit_id;
  // Accepted push that goes into a staging register
  logic           slot_load;
  // The presented push flit completes the pop flit
  logic           flit_complete;
  // Slices captured so far
  staged_slices_t staged;

  // ---------------------------------------------------------------------
  // Stages
  // ---------------------------------------------------------------------

  // Tracks the position and decides when a pop flit is complete
  slot_tracker u_slot_tracker (
    .clk           (clk),
    .arst_n        (arst_n),
    .push_valid    (push_valid),
    .push_last     (push_flit.last),
    .push_ready    (push_ready),
    .pop_ready     (pop_ready),
    .flit_id       (flit_id),
    .slot_load     (slot_load),
    .flit_complete (flit_complete)
  );

  // Captures every slice but the final one
  slice_stager u_slice_stager (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_data (push_flit.data),
    .flit_id   (flit_id),
    .slot_load (slot_load),
    .staged    (staged)
  );

  // Merges staged and live slices into the outgoing flit
  pop_assembler u_pop_assembler (
    .push_flit (push_flit),
    .flit_id   (flit_id),
    .staged    (staged),
    .pop_flit  (pop_flit)
  );

  // The pop flit is offered in the same cycle as its completing push
  assign pop_valid = flit_complete;

  // A pop flit only exists while its completing push is presented
  // and both sides transfer on the same edge
  pop_with_push_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    pop_valid |-> push_valid && (push_ready == pop_ready)
  ) else $error("deser_top: pop flit offered without its completing push");

endmodule

//--- test/deser_vectors.svh
// Table of push flits and the pop flits they are expected to produce
`ifndef DESER_VECTORS_SVH
`define DESER_VECTORS_SVH

// Columns: push data, push last, push meta, expect pop,
//          pop data, pop last, pop don't-care count, pop meta
task automatic load_vectors();
  // Full pop flit, first flit lands in the top byte
  add_row(8'hBA, 1'b0, 3'd5, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hAD, 1'b0, 3'd5, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hF0, 1'b0, 3'd5, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'h0D, 1'b0, 3'd5, 1'b1, 32'hBAAD_F00D, 1'b0, 2'd0, 3'd5);

  // Early last after three flits, the stale slot from above must read zero
  add_row(8'h0D, 1'b0, 3'd2, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hF0, 1'b0, 3'd2, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hAD, 1'b1, 3'd2, 1'b1, 32'h0DF0_AD00, 1'b1, 2'd1, 3'd2);

  // Single-flit packet completes in the cycle it is presented
  add_row(8'h5A, 1'b1, 3'd7, 1'b1, 32'h5A00_0000, 1'b1, 2'd3, 3'd7);

  // Two-flit packet leaves two trailing slots unfilled
  add_row(8'hC3, 1'b0, 3'd1, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'h3C, 1'b1, 3'd1, 1'b1, 32'hC33C_0000, 1'b1, 2'd2, 3'd1);

  // Last on the final slot gives a full flit with last set
  add_row(8'h12, 1'b0, 3'd4, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'h34, 1'b0, 3'd4, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'h56, 1'b0, 3'd4, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'h78, 1'b1, 3'd4, 1'b1, 32'h1234_5678, 1'b1, 2'd0, 3'd4);

  // Another full flit with metadata of zero
  add_row(8'hDE, 1'b0, 3'd0, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hAD, 1'b0, 3'd0, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hBE, 1'b0, 3'd0, 1'b0, 32'h0000_0000, 1'b0, 2'd0, 3'd0);
  add_row(8'hEF, 1'b0, 3'd0, 1'b1, 32'hDEAD_BEEF, 1'b0, 2'd0, 3'd0);

  // Single flit again, all three staging registers now hold stale data
  add_row(8'h81, 1'b1, 3'd6, 1'b1, 32'h8100_0000, 1'b1, 2'd3, 3'd6);
endtask

`endif

//--- test/tb_deser.sv
// Table-driven testbench for the 8-to-32 bit flit deserializer
module tb_deser;
  timeunit 1ns;
  timeprecision 100ps;

  import deser_pkg::*;

  // One row of the stimulus table and the pop flit that it should produce
  typedef struct packed {
    push_data_t data;
    logic       last;
    meta_t      meta;
    logic       expect_pop;
    pop_data_t  pop_data;
    logic       pop_last;
    flit_id_t   pop_dc;
    meta_t      pop_meta;
  } vector_t;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       push_valid;
  push_flit_t push_flit;
  logic       push_ready;
  logic       pop_valid;
  pop_flit_t  pop_flit;
  logic       pop_ready;

  vector_t vectors[$];
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  int      cycle_limit;
  int      pops = 0;

  deser_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_flit  (push_flit),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_flit   (pop_flit),
    .pop_ready  (pop_ready)
  );

  // ---------------------------------------------------------------------
  // Clock and run limit
  // ---------------------------------------------------------------------

  // 100 ns period
  always #50 clk = ~clk;

  // Each row takes at most four cycles and the limit leaves plenty of room
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // Table helpers
  // ---------------------------------------------------------------------

  task automatic add_row(input push_data_t data, input logic last, input meta_t meta,
                         input logic expect_pop, input pop_data_t pop_data,
                         input logic pop_last, input flit_id_t pop_dc,
                         input meta_t pop_meta);
    vector_t row;
    row.data       = data;
    row.last       = last;
    row.meta       = meta;
    row.expect_pop = expect_pop;
    row.pop_data   = pop_data;
    row.pop_last   = pop_last;
    row.pop_dc     = pop_dc;
    row.pop_meta   = pop_meta;
    vectors.push_back(row);
  endtask

  `include "deser_vectors.svh"

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Compares both handshake sides against the row at the falling edge
  task automatic check_outputs(input int idx, input vector_t row, input logic exp_ready);
    checks++;
    if (pop_valid !== row.expect_pop) begin
      errors++;
      $display("[ERROR] %0t: row %0d pop_valid %b, expected %b",
               $time, idx, pop_valid, row.expect_pop);
    end
    checks++;
    if (push_ready !== exp_ready) begin
      errors++;
      $display("[ERROR] %0t: row %0d push_ready %b, expected %b",
               $time, idx, push_ready, exp_ready);
    end
    // The pop fields only carry meaning while a pop flit is offered
    if (row.expect_pop) begin
      checks++;
      if (pop_flit.data !== row.pop_data) begin
        errors++;
        $display("[ERROR] %0t: row %0d pop data %h, expected %h",
                 $time, idx, pop_flit.data, row.pop_data);
      end
      checks++;
      if (pop_flit.last !== row.pop_last) begin
        errors++;
        $display("[ERROR] %0t: row %0d pop last %b, expected %b",
                 $time, idx, pop_flit.last, row.pop_last);
      end
      checks++;
      if (pop_flit.dont_care_count !== row.pop_dc) begin
        errors++;
        $display("[ERROR] %0t: row %0d don't-care count %0d, expected %0d",
                 $time, idx, pop_flit.dont_care_count, row.pop_dc);
      end
      checks++;
      if (pop_flit.meta !== row.pop_meta) begin
        errors++;
        $display("[ERROR] %0t: row %0d pop meta %0d, expected %0d",
                 $time, idx, pop_flit.meta, row.pop_meta);
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Row driver
  // ---------------------------------------------------------------------

  // Presents one row and holds it until the push side accepts it
  // A completing row sees pop_ready low for a random number of cycles first
  task automatic apply_row(input int idx);
    vector_t row;
    int      stall;
    logic    accepted;
    row   = vectors[idx];
    stall = 0;
    if (row.expect_pop) begin
      stall = $urandom % 4;
      // The first pop flit always meets back-pressure
      if (pops == 0) begin
        stall = 2;
      end
    end
    push_valid     = 1'b1;
    push_flit.data = row.data;
    push_flit.last = row.last;
    push_flit.meta = row.meta;
    accepted       = 1'b0;
    while (!accepted) begin
      if (row.expect_pop) begin
        pop_ready = (stall == 0);
      end else begin
        // Pop readiness must not matter while no pop flit is offered
        pop_ready = ($urandom % 2) == 1;
      end
      @(negedge clk);
      check_outputs(idx, row, row.expect_pop ? pop_ready : 1'b1);
      accepted = push_ready;
      @(posedge clk);
      #10;
      if (stall > 0) begin
        stall--;
      end
    end
    if (row.expect_pop) begin
      pops++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_flit  = '0;
    pop_ready  = 1'b0;
    void'($urandom(16));
    load_vectors();
    cycle_limit = vectors.size() * 8 + 50;

    // Reset held for three cycles
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;

    // Idle after reset with nothing offered and a slot open
    @(negedge clk);
    checks++;
    if (pop_valid !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: pop_valid %b after reset, expected 0", $time, pop_valid);
    end
    checks++;
    if (push_ready !== 1'b1) begin
      errors++;
      $display("[ERROR] %0t: push_ready %b after reset, expected 1", $time, push_ready);
    end
    @(posedge clk);
    #10;

    for (int i = 0; i < vectors.size(); i++) begin
      apply_row(i);
    end
    push_valid = 1'b0;
    pop_ready  = 1'b0;
    @(posedge clk);

    $display("Summary: %0d rows, %0d pop flits, %0d checks, %0d errors",
             vectors.size(), pops, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+hdl
+incdir+test
hdl/deser_pkg.sv
hdl/slot_tracker.sv
hdl/slice_stager.sv
hdl/pop_assembler.sv
hdl/deser_top.sv
test/tb_deser.sv

//--- run_sim.sh
#!/bin/sh
# Builds the deserializer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_deser -f all.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The run only counts as passing when the testbench printed its pass line
if grep -q "^Finished with no errors$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
